// ==== src/cpu_regs_pkg.sv ====
// CPU register file definitions
// Widths of register words and memory addresses, the opcode byte codes
// that name the 32-bit general registers, and the "no base" selector.
`default_nettype none

package cpu_regs_pkg;

    localparam int REG_W    = 32;                 // general register width
    localparam int ADDR_W   = 24;                 // external address bus
    localparam int SEL_W    = 8;                  // opcode register byte code
    localparam int NUM_REGS = 8;                  // XWA .. XSP
    localparam int IDX_W    = $clog2(NUM_REGS);

    typedef logic [REG_W-1:0]  reg_word_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [SEL_W-1:0]  reg_sel_t;
    typedef logic [IDX_W-1:0]  reg_idx_t;

    // 32-bit registers are coded E0, E4, E8 ... FC
    // bits 4..2 give the bank index, bits 1..0 the byte lane
    localparam reg_sel_t FULL_REG_BASE = 8'he0;   // XWA

    // base selector meaning no register, reads as zero
    localparam reg_sel_t NULL_SEL = 8'h40;

endpackage

`default_nettype wire

// ==== src/ea_mode_pkg.sv ====
// Effective-address mode definitions
// Mode keys built from the first operand byte, the pre-decrement and
// post-increment step codes, the byte count type and the decoder states.
`default_nettype none

package ea_mode_pkg;

    // key is {byte0[6], byte0[3:0]}
    typedef logic [4:0] mode_t;

    localparam mode_t MODE_IMM8    = 5'h10;   // (#8)
    localparam mode_t MODE_IMM16   = 5'h11;   // (#16)
    localparam mode_t MODE_IMM24   = 5'h12;   // (#24)
    localparam mode_t MODE_LONG    = 5'h13;   // (r32) (r32+d16) (r32+r8/r16)
    localparam mode_t MODE_PREDEC  = 5'h14;   // (-r32)
    localparam mode_t MODE_POSTINC = 5'h15;   // (r32+)

    typedef logic [1:0] step_t;

    localparam step_t STEP_1 = 2'd0;
    localparam step_t STEP_2 = 2'd1;
    localparam step_t STEP_4 = 2'd2;

    typedef logic [2:0] fetch_cnt_t;

    typedef enum logic [1:0] {
        EA_IDLE,   // waiting for start
        EA_EXT,    // waiting for the extension word
        EA_ADD     // forming the address
    } ea_state_t;

    // byte size of a step code, code 3 is reserved
    function automatic logic [2:0] step_bytes(step_t step);
        case (step)
            STEP_1:  return 3'd1;
            STEP_2:  return 3'd2;
            STEP_4:  return 3'd4;
            default: return 3'd0;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== src/ea_reg_bank.sv ====
// General register bank for the address unit
// Eight 32-bit registers with a base read port, an index read port that
// returns the addressed byte or word lane, an external load port and the
// increment/decrement write-back used by (-r32) and (r32+).
`timescale 1ns/1ps
`default_nettype none

module ea_reg_bank (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cen,
    input  cpu_regs_pkg::reg_sel_t  base_sel,
    input  cpu_regs_pkg::reg_sel_t  index_sel,
    input  logic                    wr_en,
    input  cpu_regs_pkg::reg_idx_t  wr_idx,
    input  cpu_regs_pkg::reg_word_t wr_data,
    input  logic                    wb_inc,
    input  logic                    wb_dec,
    input  ea_mode_pkg::step_t      wb_step,
    input  cpu_regs_pkg::reg_sel_t  wb_sel,
    output cpu_regs_pkg::reg_word_t base_val,
    output cpu_regs_pkg::reg_word_t index_val
);

    cpu_regs_pkg::reg_word_t regs [cpu_regs_pkg::NUM_REGS];

    cpu_regs_pkg::reg_idx_t  base_idx;
    cpu_regs_pkg::reg_idx_t  index_idx;
    cpu_regs_pkg::reg_idx_t  wb_idx;
    cpu_regs_pkg::reg_word_t wb_amt;

    assign base_idx  = base_sel[4:2];    // E0 -> 0 ... FC -> 7
    assign index_idx = index_sel[4:2];
    assign wb_idx    = wb_sel[4:2];

    assign wb_amt = {29'd0, ea_mode_pkg::step_bytes(wb_step)};

    assign base_val = (base_sel == cpu_regs_pkg::NULL_SEL) ? '0 : regs[base_idx];

    // lane select only, sign extension is left to the decoder
    assign index_val = regs[index_idx] >> {index_sel[1:0], 3'b000};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < cpu_regs_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (cen) begin
            if (wr_en) begin
                regs[wr_idx] <= wr_data;               // host load wins
            end else if (wb_inc) begin
                regs[wb_idx] <= regs[wb_idx] + wb_amt; // (r32+)
            end else if (wb_dec) begin
                regs[wb_idx] <= regs[wb_idx] - wb_amt; // (-r32)
            end
        end
    end

    a_wb_exclusive: assert property (
        @(posedge clk) disable iff (rst)
        !(wb_inc && wb_dec)
    ) else $error("increment and decrement write-back requested together");

    a_wb_step_valid: assert property (
        @(posedge clk) disable iff (rst)
        (wb_inc || wb_dec) |-> (wb_step != 2'd3)
    ) else $error("write-back with reserved step code");

endmodule

`default_nettype wire

// ==== src/ea_calc.sv ====
// Effective-address decoder and adder
// Decodes the memory operand prefix byte, picks base register, offset or
// index, waits for the extension word of the long (r32+d16) and indexed
// forms, and adds everything into a 24-bit address. Pre-decrement and
// post-increment modes raise a write-back strobe toward the register bank.
`timescale 1ns/1ps
`default_nettype none

module ea_calc (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cen,
    input  logic                     start,
    input  logic                     ext,
    input  logic [31:0]              op,
    input  cpu_regs_pkg::reg_word_t  base_val,
    input  cpu_regs_pkg::reg_word_t  index_val,
    output cpu_regs_pkg::reg_sel_t   base_sel,
    output cpu_regs_pkg::reg_sel_t   index_sel,
    output logic                     wb_inc,
    output logic                     wb_dec,
    output ea_mode_pkg::step_t       wb_step,
    output cpu_regs_pkg::reg_sel_t   wb_sel,
    output logic                     done,
    output logic                     need_ext,
    output cpu_regs_pkg::addr_t      addr,
    output ea_mode_pkg::fetch_cnt_t  fetched
);

    ea_mode_pkg::ea_state_t   state;
    ea_mode_pkg::mode_t       mode_key;

    // decoded from the first word
    cpu_regs_pkg::reg_sel_t   dec_base;
    cpu_regs_pkg::addr_t      dec_off;
    ea_mode_pkg::fetch_cnt_t  dec_fetch;
    ea_mode_pkg::step_t       dec_step;
    logic                     dec_inc;
    logic                     dec_dec;
    logic                     dec_ext;

    // held for the add step
    cpu_regs_pkg::addr_t      offset;
    ea_mode_pkg::step_t       step_q;
    ea_mode_pkg::fetch_cnt_t  fetch_q;
    logic                     index16;
    logic                     use_index;
    logic                     inc_pend;
    logic                     dec_pend;
    logic                     sum_ok;

    logic                     start_acc;
    logic                     ext_acc;
    cpu_regs_pkg::addr_t      pre_amt;
    cpu_regs_pkg::addr_t      idx_ext;
    cpu_regs_pkg::addr_t      sum;

    assign mode_key  = {op[6], op[3:0]};
    assign start_acc = cen && start && (state == ea_mode_pkg::EA_IDLE);
    assign ext_acc   = cen && ext && need_ext && (state == ea_mode_pkg::EA_EXT);

    assign wb_step = step_q;
    assign wb_sel  = base_sel;    // write-back goes to the base register

    always_comb begin
        dec_base  = cpu_regs_pkg::NULL_SEL;
        dec_off   = '0;
        dec_fetch = 3'd1;
        dec_step  = ea_mode_pkg::STEP_1;
        dec_inc   = 1'b0;
        dec_dec   = 1'b0;
        dec_ext   = 1'b0;
        casez (mode_key)
            5'b0_????: begin    // short form (r32) (r32+d8)
                dec_base  = cpu_regs_pkg::FULL_REG_BASE | {3'b000, op[2:0], 2'b00};
                dec_off   = op[3] ? {{16{op[15]}}, op[15:8]} : '0;
                dec_fetch = op[3] ? 3'd2 : 3'd1;
            end
            ea_mode_pkg::MODE_IMM8: begin
                dec_off   = {16'd0, op[15:8]};
                dec_fetch = 3'd2;
            end
            ea_mode_pkg::MODE_IMM16: begin
                dec_off   = {8'd0, op[23:8]};
                dec_fetch = 3'd3;
            end
            ea_mode_pkg::MODE_IMM24: begin
                dec_off   = op[31:8];
                dec_fetch = 3'd4;
            end
            ea_mode_pkg::MODE_LONG: begin
                dec_base  = {op[15:10], 2'b00};
                dec_fetch = 3'd2;
                dec_ext   = op[8];      // 01 d16, 11 indexed
            end
            ea_mode_pkg::MODE_PREDEC, ea_mode_pkg::MODE_POSTINC: begin
                dec_base  = {op[15:10], 2'b00};
                dec_step  = op[9:8];
                dec_dec   = !mode_key[0];
                dec_inc   = mode_key[0];
                dec_fetch = 3'd2;
            end
            default: ;                  // unsupported key, address zero
        endcase
    end

    // pre-decrement happens before the add
    assign pre_amt = dec_pend ? {21'd0, ea_mode_pkg::step_bytes(step_q)} : '0;

    assign idx_ext = index16 ? {{8{index_val[15]}}, index_val[15:0]}
                             : {{16{index_val[7]}}, index_val[7:0]};

    assign sum = base_val[cpu_regs_pkg::ADDR_W-1:0] - pre_amt + (use_index ? idx_ext : offset);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= ea_mode_pkg::EA_IDLE;
            sum_ok    <= 1'b0;
            need_ext  <= 1'b0;
            done      <= 1'b0;
            fetched   <= '0;
            wb_inc    <= 1'b0;
            wb_dec    <= 1'b0;
            inc_pend  <= 1'b0;
            dec_pend  <= 1'b0;
            use_index <= 1'b0;
        end else if (cen) begin
            done    <= 1'b0;            // one-cycle strobes
            fetched <= '0;
            wb_inc  <= 1'b0;
            wb_dec  <= 1'b0;
            case (state)
                ea_mode_pkg::EA_IDLE: begin
                    if (start_acc) begin
                        inc_pend  <= dec_inc;
                        dec_pend  <= dec_dec;
                        use_index <= dec_ext && op[9];
                        state     <= dec_ext ? ea_mode_pkg::EA_EXT : ea_mode_pkg::EA_ADD;
                    end
                end
                ea_mode_pkg::EA_EXT: begin
                    if (!need_ext) begin
                        need_ext <= 1'b1;   // first word consumed
                        fetched  <= 3'd2;
                    end else if (ext_acc) begin
                        need_ext <= 1'b0;
                        state    <= ea_mode_pkg::EA_ADD;
                    end
                end
                ea_mode_pkg::EA_ADD: begin
                    if (!sum_ok) begin
                        sum_ok <= 1'b1;
                        wb_inc <= inc_pend; // lands with done
                        wb_dec <= dec_pend;
                    end else begin
                        sum_ok  <= 1'b0;
                        done    <= 1'b1;
                        fetched <= fetch_q;
                        state   <= ea_mode_pkg::EA_IDLE;
                    end
                end
                default: state <= ea_mode_pkg::EA_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_acc) begin
            base_sel <= dec_base;
            offset   <= dec_off;
            step_q   <= dec_step;
            fetch_q  <= dec_fetch;
            index16  <= op[10];         // r16 index when set
        end
        if (ext_acc) begin
            if (use_index) begin
                base_sel  <= op[7:0];   // ext byte 0 is base
                index_sel <= op[15:8];  // ext byte 1 is index
            end else begin
                offset <= {{8{op[15]}}, op[15:0]};
            end
        end
        if (cen && (state == ea_mode_pkg::EA_ADD) && !sum_ok) begin
            addr <= sum;
        end
    end

    a_done_vs_ext: assert property (
        @(posedge clk) disable iff (rst)
        !(done && need_ext)
    ) else $error("done raised while still waiting for the extension word");

endmodule

`default_nettype wire

// ==== src/ea_unit.sv ====
// Effective-address unit, top level
// Connects the mode decoder/adder with the general register bank.
// The host loads registers through the write port, starts a request
// with the mode word on op, answers need_ext with an extension word and
// gets the 24-bit address and the consumed byte count with done.
`timescale 1ns/1ps
`default_nettype none

module ea_unit (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cen,
    input  logic                     start,
    input  logic                     ext,
    input  logic [31:0]              op,
    input  logic                     wr_en,
    input  cpu_regs_pkg::reg_idx_t   wr_idx,
    input  cpu_regs_pkg::reg_word_t  wr_data,
    output logic                     done,
    output logic                     need_ext,
    output cpu_regs_pkg::addr_t      addr,
    output ea_mode_pkg::fetch_cnt_t  fetched
);

    cpu_regs_pkg::reg_sel_t  base_sel;
    cpu_regs_pkg::reg_sel_t  index_sel;
    cpu_regs_pkg::reg_word_t base_val;
    cpu_regs_pkg::reg_word_t index_val;
    logic                    wb_inc;
    logic                    wb_dec;
    ea_mode_pkg::step_t      wb_step;
    cpu_regs_pkg::reg_sel_t  wb_sel;

    ea_calc calc_i (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .start     (start),
        .ext       (ext),
        .op        (op),
        .base_val  (base_val),
        .index_val (index_val),
        .base_sel  (base_sel),
        .index_sel (index_sel),
        .wb_inc    (wb_inc),
        .wb_dec    (wb_dec),
        .wb_step   (wb_step),
        .wb_sel    (wb_sel),
        .done      (done),
        .need_ext  (need_ext),
        .addr      (addr),
        .fetched   (fetched)
    );

    ea_reg_bank bank_i (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .base_sel  (base_sel),
        .index_sel (index_sel),
        .wr_en     (wr_en),
        .wr_idx    (wr_idx),
        .wr_data   (wr_data),
        .wb_inc    (wb_inc),
        .wb_dec    (wb_dec),
        .wb_step   (wb_step),
        .wb_sel    (wb_sel),
        .base_val  (base_val),
        .index_val (index_val)
    );

endmodule

`default_nettype wire

// ==== verif/ea_unit_tb.sv ====
// Testbench for the effective-address unit
// Directed tests over the short, immediate, long, extension-word and
// pre-decrement/post-increment modes, checked against a register model.
`timescale 1ns/1ps
`default_nettype none

module ea_unit_tb;

    localparam int CLK_PERIOD = 20;
    localparam int NUM_TESTS  = 6;

    logic                    clk = 1'b0;
    logic                    rst;
    logic                    cen;
    logic                    start;
    logic                    ext;
    logic [31:0]             op;
    logic                    wr_en;
    cpu_regs_pkg::reg_idx_t  wr_idx;
    cpu_regs_pkg::reg_word_t wr_data;
    logic                    done;
    logic                    need_ext;
    cpu_regs_pkg::addr_t     addr;
    ea_mode_pkg::fetch_cnt_t fetched;

    logic [31:0] model_regs [8];   // mirror of the register bank
    logic [15:0] lfsr_state;

    ea_unit dut_i (
        .clk (clk), .rst (rst), .cen (cen), .start (start), .ext (ext), .op (op),
        .wr_en (wr_en), .wr_idx (wr_idx), .wr_data (wr_data),
        .done (done), .need_ext (need_ext), .addr (addr), .fetched (fetched)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [23:0] sext8(input logic [7:0] v);
        return {{16{v[7]}}, v};
    endfunction

    function automatic logic [23:0] sext16(input logic [15:0] v);
        return {{8{v[15]}}, v};
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] want, input string what);
        if (got !== want) begin
            $display("ERR %0t ns %s: got %0h, expected %0h", $time, what, got, want);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic load_reg(input logic [2:0] idx, input logic [31:0] val);
        @(negedge clk);
        wr_en   = 1'b1;
        wr_idx  = idx;
        wr_data = val;
        @(negedge clk);
        wr_en = 1'b0;
        model_regs[idx] = val;
    endtask

    task automatic issue_start(input logic [31:0] op_word);
        @(negedge clk);
        start = 1'b1;
        op    = op_word;
        @(negedge clk);
        start = 1'b0;                  // accepted at the edge in between
    endtask

    // counts falling edges until done is seen
    task automatic wait_done(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > 10 && !done) begin
                $display("TEST FAIL");
                $fatal(1, "done did not arrive within 10 cycles");
            end
        end while (!done);
    endtask

    task automatic run_single(input logic [31:0] op_word, input logic [23:0] exp_addr,
                              input int exp_fetch, input string what);
        int lat;
        issue_start(op_word);
        wait_done(lat);
        check_eq(32'(lat), 32'd2, {what, " latency"});
        check_eq(32'(addr), 32'(exp_addr), {what, " addr"});
        check_eq(32'(fetched), 32'(exp_fetch), {what, " fetched"});
    endtask

    task automatic run_ext(input logic [31:0] op_word, input logic [31:0] ext_word,
                           input logic [23:0] exp_addr, input string what);
        int lat;
        int delay;
        issue_start(op_word);
        @(negedge clk);
        check_eq(32'(need_ext), 32'd1, {what, " need_ext rise"});
        check_eq(32'(fetched), 32'd2, {what, " first fetched"});
        delay = int'(rand_bits(2));
        repeat (delay) begin
            @(negedge clk);
            check_eq(32'(need_ext), 32'd1, {what, " need_ext held"});
            check_eq(32'(done), 32'd0, {what, " early done"});
        end
        ext = 1'b1;
        op  = ext_word;
        @(negedge clk);
        ext = 1'b0;
        check_eq(32'(need_ext), 32'd0, {what, " need_ext drop"});
        wait_done(lat);
        check_eq(32'(lat), 32'd2, {what, " latency"});
        check_eq(32'(addr), 32'(exp_addr), {what, " addr"});
        check_eq(32'(fetched), 32'd2, {what, " fetched"});
    endtask

    task automatic test_reset_imm24();
        logic [23:0] off;
        check_eq(32'(done), 32'd0, "reset done");
        check_eq(32'(need_ext), 32'd0, "reset need_ext");
        check_eq(32'(fetched), 32'd0, "reset fetched");
        off = 24'(rand_bits(24));
        run_single({off, 8'hc2}, off, 4, "imm24");
    endtask

    task automatic test_short_form();
        logic [7:0] d8;
        for (int r = 0; r < 8; r++) begin
            load_reg(3'(r), rand_bits(32));
        end
        for (int r = 0; r < 8; r++) begin
            d8 = 8'(rand_bits(8));
            run_single({24'h0, 8'h80 | 8'(r)}, model_regs[r][23:0], 1, "short r32");
            run_single({16'h0, d8, 8'h88 | 8'(r)}, model_regs[r][23:0] + sext8(d8), 2,
                       "short r32+d8");
        end
    endtask

    task automatic test_imm_long();
        logic [7:0]  d8;
        logic [15:0] d16;
        d8  = 8'(rand_bits(8));
        d16 = 16'(rand_bits(16));
        run_single({16'h0, d8, 8'hc0}, {16'h0, d8}, 2, "imm8");
        run_single({8'h0, d16, 8'hc1}, {8'h0, d16}, 3, "imm16");
        for (int r = 0; r < 8; r++) begin
            run_single({16'h0, 8'he0 | 8'(r << 2), 8'hc3}, model_regs[r][23:0], 2, "long r32");
        end
    endtask

    task automatic test_ext_modes();
        logic [2:0]  b;
        logic [2:0]  x;
        logic [1:0]  lane;
        logic        w16;
        logic [15:0] d16;
        logic [31:0] ival;
        logic [23:0] exp_addr;
        for (int i = 0; i < 4; i++) begin
            b   = 3'(rand_bits(3));
            d16 = 16'(rand_bits(16));
            exp_addr = model_regs[b][23:0] + sext16(d16);
            run_ext({16'h0, 8'he1 | {3'd0, b, 2'd0}, 8'hc3}, {16'h0, d16}, exp_addr, "long d16");
        end
        for (int i = 0; i < 6; i++) begin
            b    = 3'(rand_bits(3));
            x    = 3'(rand_bits(3));
            w16  = 1'(rand_bits(1));
            lane = w16 ? {1'(rand_bits(1)), 1'b0} : 2'(rand_bits(2));   // word lanes 0 or 2
            ival = model_regs[x] >> (8 * int'(lane));
            exp_addr = model_regs[b][23:0] + (w16 ? sext16(ival[15:0]) : sext8(ival[7:0]));
            run_ext({16'h0, 8'h03 | {5'd0, w16, 2'd0}, 8'hc3},
                    {16'h0, 8'he0 | {3'd0, x, lane}, 8'he0 | {3'd0, b, 2'd0}},
                    exp_addr, "long indexed");
        end
    endtask

    task automatic test_pre_post();
        logic [2:0]  r;
        logic [31:0] bytes;
        logic [23:0] exp_addr;
        for (int s = 0; s < 3; s++) begin
            for (int m = 0; m < 2; m++) begin
                r     = 3'(rand_bits(3));
                bytes = 32'd1 << s;
                if (m == 0) begin
                    exp_addr = model_regs[r][23:0] - bytes[23:0];
                    model_regs[r] = model_regs[r] - bytes;
                end else begin
                    exp_addr = model_regs[r][23:0];
                    model_regs[r] = model_regs[r] + bytes;
                end
                run_single({16'h0, 8'he0 | {3'd0, r, 2'(s)}, 8'hc4 | 8'(m)}, exp_addr, 2,
                           m == 0 ? "pre-decrement" : "post-increment");
                run_single({16'h0, 8'he0 | {3'd0, r, 2'd0}, 8'hc3}, model_regs[r][23:0], 2,
                           "after write-back");
            end
        end
    endtask

    task automatic test_cen_hold();
        logic [2:0]  r;
        logic [7:0]  d8;
        logic [23:0] exp_addr;
        logic [23:0] prev_addr;
        int          hold;
        int          lat;
        r    = 3'(rand_bits(3));
        d8   = 8'(rand_bits(8));
        hold = int'(rand_bits(3)) + 1;
        prev_addr = addr;
        exp_addr  = model_regs[r][23:0] + sext8(d8);
        if (exp_addr == prev_addr) begin
            d8       = d8 ^ 8'h01;     // old and new address must differ
            exp_addr = model_regs[r][23:0] + sext8(d8);
        end
        issue_start({16'h0, d8, 8'h88 | {5'd0, r}});
        cen = 1'b0;                    // frozen before the address is formed
        repeat (hold) begin
            @(negedge clk);
            check_eq(32'(done), 32'd0, "cen hold done");
            check_eq(32'(addr), 32'(prev_addr), "cen hold addr held");
        end
        cen = 1'b1;
        wait_done(lat);
        check_eq(32'(hold + lat), 32'(hold + 2), "cen hold latency");
        check_eq(32'(addr), 32'(exp_addr), "cen hold addr");
        check_eq(32'(fetched), 32'd2, "cen hold fetched");
    endtask

    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("TEST FAIL");
        $fatal(1, "watchdog expired before the tests finished");
    end

    initial begin
        lfsr_state = 16'd38783;
        rst     = 1'b1;
        cen     = 1'b1;
        start   = 1'b0;
        ext     = 1'b0;
        op      = '0;
        wr_en   = 1'b0;
        wr_idx  = '0;
        wr_data = '0;
        for (int i = 0; i < 8; i++) begin
            model_regs[i] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_reset_imm24();
        test_short_form();
        test_imm_long();
        test_ext_modes();
        test_pre_post();
        test_cen_hold();
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
src/cpu_regs_pkg.sv
src/ea_mode_pkg.sv
src/ea_reg_bank.sv
src/ea_calc.sv
src/ea_unit.sv
verif/ea_unit_tb.sv

// ==== Makefile ====
# Verilator build, run and lint for the effective-address unit

TOP := ea_unit_tb

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): sources.f $(wildcard src/*.sv verif/*.sv)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sources.f

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir
